// File: hdl/id_pkg.sv
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [reg_addr_w-1:0] reg_ra = 5'd31;  // jal link register

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function field of special, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_srl     = 6'h02,
        fn_sra     = 6'h03,
        fn_jr      = 6'h08,
        fn_syscall = 6'h0c,
        fn_break   = 6'h0d,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_xor     = 6'h26,
        fn_nor     = 6'h27,
        fn_slt     = 6'h2a,
        fn_sltu    = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        src2_reg,     // rt value
        src2_zimm,    // zero-extended imm
        src2_simm,    // sign-extended imm
        src2_const8   // return address offset for jal
    } src2_sel_t;

    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10
    } exc_code_t;

endpackage

// File: hdl/id_regfile.sv
module id_regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

    // waddr of zero doubles as the write enable
    always_ff @(posedge clk) begin
        if (waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is not visible here, wb bypass covers it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a write shows up on both read ports from the next cycle on
    a_read_after_write: assert property (@(posedge clk) $past(waddr) != '0 |->
        (raddr1 != $past(waddr) || rdata1 == $past(wdata)) &&
        (raddr2 != $past(waddr) || rdata2 == $past(wdata)))
        else $error("register file read back a stale value");

endmodule

// File: hdl/id_decoder.sv
module id_decoder import id_pkg::*; (
    input  logic [xlen-1:0]       inst,
    output logic [reg_addr_w-1:0] rs,
    output logic [reg_addr_w-1:0] rt,
    output alu_op_t               alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output src2_sel_t             src2_sel,
    output logic                  load,
    output logic                  mem_we,
    output logic [reg_addr_w-1:0] dest,
    output logic [15:0]           imm,
    output logic [25:0]           jidx,
    output logic                  rs_used,
    output logic                  rt_used,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  is_jr,
    output logic                  is_jump,   // j or jal
    output exc_code_t             exc_code
);

    opcode_t               op;
    funct_t                fn;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] sa;
    logic                  defined;

    assign op   = opcode_t'(inst[31:26]);
    assign fn   = funct_t'(inst[5:0]);
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    always_comb begin
        alu_op     = alu_add;
        src1_is_sa = 1'b0;
        src1_is_pc = 1'b0;
        src2_sel   = src2_reg;
        load       = 1'b0;
        mem_we     = 1'b0;
        dest       = '0;
        rs_used    = 1'b0;
        rt_used    = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        is_jr      = 1'b0;
        is_jump    = 1'b0;
        exc_code   = exc_none;
        defined    = 1'b1;
        case (op)
            op_special: begin
                dest    = rd;
                rs_used = 1'b1;
                rt_used = 1'b1;
                defined = (sa == '0);  // three-register forms keep sa clear
                case (fn)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    fn_jr: begin
                        dest    = '0;
                        rt_used = 1'b0;
                        is_jr   = 1'b1;
                        defined = (rt == '0) && (rd == '0) && (sa == '0);
                    end
                    fn_syscall: begin
                        dest     = '0;
                        rs_used  = 1'b0;
                        rt_used  = 1'b0;
                        defined  = 1'b1;  // code field spans rs..sa
                        exc_code = exc_sys;
                    end
                    fn_break: begin
                        dest     = '0;
                        rs_used  = 1'b0;
                        rt_used  = 1'b0;
                        defined  = 1'b1;
                        exc_code = exc_bp;
                    end
                    default: defined = 1'b0;
                endcase
                // shifts take sa as operand 1, rs must be zero
                if (fn inside {fn_sll, fn_srl, fn_sra}) begin
                    src1_is_sa = 1'b1;
                    rs_used    = 1'b0;
                    defined    = (rs == '0);
                end
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui, op_lw: begin
                dest    = rt;
                rs_used = (op != op_lui);
                defined = (op != op_lui) || (rs == '0);
                load    = (op == op_lw);
                if (op inside {op_andi, op_ori, op_xori, op_lui})
                    src2_sel = src2_zimm;
                else
                    src2_sel = src2_simm;
                case (op)
                    op_slti:  alu_op = alu_slt;
                    op_sltiu: alu_op = alu_sltu;
                    op_andi:  alu_op = alu_and;
                    op_ori:   alu_op = alu_or;
                    op_xori:  alu_op = alu_xor;
                    op_lui:   alu_op = alu_lui;
                    default:  alu_op = alu_add;  // addiu, lw address
                endcase
            end
            op_sw: begin
                rs_used  = 1'b1;
                rt_used  = 1'b1;
                src2_sel = src2_simm;
                mem_we   = 1'b1;
            end
            op_beq, op_bne: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                is_beq  = (op == op_beq);
                is_bne  = (op == op_bne);
            end
            op_j: is_jump = 1'b1;
            op_jal: begin
                is_jump    = 1'b1;
                dest       = reg_ra;
                src1_is_pc = 1'b1;       // link value pc + 8
                src2_sel   = src2_const8;
            end
            default: defined = 1'b0;
        endcase
        // reserved instruction must not write, read or branch
        if (!defined) begin
            dest     = '0;
            rs_used  = 1'b0;
            rt_used  = 1'b0;
            load     = 1'b0;
            mem_we   = 1'b0;
            is_beq   = 1'b0;
            is_bne   = 1'b0;
            is_jr    = 1'b0;
            is_jump  = 1'b0;
            exc_code = exc_ri;
        end
    end

endmodule

// File: hdl/id_bypass.sv
module id_bypass import id_pkg::*; (
    input  logic [reg_addr_w-1:0] rs,
    input  logic [reg_addr_w-1:0] rt,
    input  logic                  rs_used,
    input  logic                  rt_used,
    input  logic [reg_addr_w-1:0] exe_dest,
    input  logic [reg_addr_w-1:0] mem_dest,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [xlen-1:0]       exe_result,
    input  logic [xlen-1:0]       mem_result,
    input  logic [xlen-1:0]       wb_result,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    input  logic                  exe_load,
    output logic [xlen-1:0]       rs_value,
    output logic [xlen-1:0]       rt_value,
    output logic                  load_stall
);

    // r0 never matches, so a zero dest is never forwarded
    function automatic logic hit(input logic [reg_addr_w-1:0] src, input logic used,
                                 input logic [reg_addr_w-1:0] stage_dest);
        return used && (src != '0) && (src == stage_dest);
    endfunction

    // youngest producer wins
    always_comb begin
        if (hit(rs, rs_used, exe_dest))
            rs_value = exe_result;
        else if (hit(rs, rs_used, mem_dest))
            rs_value = mem_result;
        else if (hit(rs, rs_used, wb_dest))
            rs_value = wb_result;
        else
            rs_value = rf_rdata1;
        if (hit(rt, rt_used, exe_dest))
            rt_value = exe_result;
        else if (hit(rt, rt_used, mem_dest))
            rt_value = mem_result;
        else if (hit(rt, rt_used, wb_dest))
            rt_value = wb_result;
        else
            rt_value = rf_rdata2;
    end

    // load data is not ready until mem
    assign load_stall = exe_load && (hit(rs, rs_used, exe_dest) || hit(rt, rt_used, exe_dest));

endmodule

// File: hdl/id_branch.sv
module id_branch import id_pkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs_value,
    input  logic [xlen-1:0] rt_value,
    input  logic [15:0]     imm,
    input  logic [25:0]     jidx,
    input  logic            is_beq,
    input  logic            is_bne,
    input  logic            is_jr,
    input  logic            is_jump,
    input  logic            load_stall,
    output logic            taken,
    output logic [xlen-1:0] target,
    output logic            stall
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_offset;
    logic            rs_eq_rt;

    assign pc_plus4  = pc + xlen'(4);
    assign br_offset = {{(xlen-18){imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    assign taken = (is_beq && rs_eq_rt) || (is_bne && !rs_eq_rt) || is_jr || is_jump;

    always_comb begin
        if (is_jr)
            target = rs_value;
        else if (is_jump)
            target = {pc_plus4[xlen-1:xlen-4], jidx, 2'b00};  // region of the delay slot
        else
            target = pc_plus4 + br_offset;
    end

    // operands not final yet, fetch must wait
    assign stall = load_stall && taken;

endmodule

// File: hdl/id_stage.sv
module id_stage import id_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  fs_to_ds_valid,
    input  logic [xlen-1:0]       fs_inst,
    input  logic [xlen-1:0]       fs_pc,
    input  logic                  es_allowin,
    input  logic [reg_addr_w-1:0] exe_dest, mem_dest, wb_dest,
    input  logic [xlen-1:0]       exe_result, mem_result, wb_result,
    input  logic                  exe_load,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output alu_op_t               es_alu_op,
    output logic                  es_src1_is_sa,
    output logic                  es_src1_is_pc,
    output src2_sel_t             es_src2_sel,
    output logic                  es_load,
    output logic                  es_mem_we,
    output logic [reg_addr_w-1:0] es_dest,
    output logic [15:0]           es_imm,
    output logic [xlen-1:0]       es_rs_value, es_rt_value,
    output logic [xlen-1:0]       es_pc,
    output exc_code_t             es_exc_code,
    output logic                  br_taken,
    output logic [xlen-1:0]       br_target,
    output logic                  br_stall
);

    logic                  ds_valid;
    logic [xlen-1:0]       ds_inst;
    logic [xlen-1:0]       ds_pc;
    logic [reg_addr_w-1:0] rs, rt;
    logic                  rs_used, rt_used;
    logic [25:0]           jidx;
    logic                  is_beq, is_bne, is_jr, is_jump;
    logic [xlen-1:0]       rf_rdata1, rf_rdata2;
    logic                  load_stall;
    logic                  taken, stall;

    assign ds_allowin     = !ds_valid || (!load_stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !load_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    assign es_pc = ds_pc;

    // decoded fields of an empty stage are stale, so gate what fetch sees
    assign br_taken = ds_valid && taken;
    assign br_stall = ds_valid && stall;

    id_regfile u_regfile (
        .clk,
        .raddr1 (rs),       .raddr2 (rt),
        .waddr  (wb_dest),  .wdata  (wb_result),
        .rdata1 (rf_rdata1), .rdata2 (rf_rdata2)
    );

    id_decoder u_decoder (
        .inst       (ds_inst),
        .rs, .rt,
        .alu_op     (es_alu_op),
        .src1_is_sa (es_src1_is_sa), .src1_is_pc (es_src1_is_pc),
        .src2_sel   (es_src2_sel),
        .load       (es_load),       .mem_we     (es_mem_we),
        .dest       (es_dest),       .imm        (es_imm),
        .jidx, .rs_used, .rt_used,
        .is_beq, .is_bne, .is_jr, .is_jump,
        .exc_code   (es_exc_code)
    );

    id_bypass u_bypass (
        .rs, .rt, .rs_used, .rt_used,
        .exe_dest, .mem_dest, .wb_dest,
        .exe_result, .mem_result, .wb_result,
        .rf_rdata1, .rf_rdata2, .exe_load,
        .rs_value   (es_rs_value), .rt_value (es_rt_value),
        .load_stall
    );

    id_branch u_branch (
        .pc         (ds_pc),
        .rs_value   (es_rs_value), .rt_value (es_rt_value),
        .imm        (es_imm),
        .jidx, .is_beq, .is_bne, .is_jr, .is_jump, .load_stall,
        .taken, .target (br_target), .stall
    );

    // valid out only rises for an instruction held or just accepted, never after flush
    a_valid_needs_inst: assert property (@(posedge clk) disable iff (reset)
        $rose(ds_to_es_valid) |-> !$past(flush) && ($past(ds_valid) || $past(fs_to_ds_valid)))
        else $error("ds_to_es_valid rose with an empty stage");

endmodule

// File: bench/tb_id_stage.sv
module tb_id_stage import id_pkg::*; ();

    localparam int vec_w    = 340;
    localparam int max_vecs = 64;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  flush;
    logic                  fs_to_ds_valid;
    logic [xlen-1:0]       fs_inst, fs_pc;
    logic                  es_allowin;
    logic [reg_addr_w-1:0] exe_dest, mem_dest, wb_dest;
    logic [xlen-1:0]       exe_result, mem_result, wb_result;
    logic                  exe_load;
    logic                  ds_allowin, ds_to_es_valid;
    alu_op_t               es_alu_op;
    logic                  es_src1_is_sa, es_src1_is_pc;
    src2_sel_t             es_src2_sel;
    logic                  es_load, es_mem_we;
    logic [reg_addr_w-1:0] es_dest;
    logic [15:0]           es_imm;
    logic [xlen-1:0]       es_rs_value, es_rt_value, es_pc;
    exc_code_t             es_exc_code;
    logic                  br_taken, br_stall;
    logic [xlen-1:0]       br_target;

    logic [vec_w-1:0] vecs [0:max_vecs-1];
    int               nvec;
    int               errors;
    int               test_errs;
    int               tests_run;
    int               tests_failed;
    logic [7:0]       cur_test;
    logic [xlen-1:0]  held_inst, held_pc;  // instruction the stage should hold

    id_stage u_id_stage (.*);

    always #50 clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: test %0d %s is %h, expected %h", $time, cur_test, name,
                     got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // input fields of one vector, driven after a falling edge
    task automatic drive_vector(input logic [vec_w-1:0] v);
        fs_to_ds_valid = 1'b1;
        fs_inst        = v[331:300];
        fs_pc          = v[299:268];
        es_allowin     = v[264];
        flush          = v[260];
        exe_dest       = v[256:252];
        exe_result     = v[251:220];
        mem_dest       = v[216:212];
        mem_result     = v[211:180];
        wb_dest        = v[176:172];
        wb_result      = v[171:140];
        exe_load       = v[136];
    endtask

    // flags and fields that follow straight from the held instruction
    task automatic check_side_fields(input logic [xlen-1:0] inst, input logic [xlen-1:0] pc);
        logic [5:0] op;
        logic       shift;
        op    = inst[31:26];
        shift = (op == op_special) && (inst[5:0] inside {fn_sll, fn_srl, fn_sra});
        check_field("load", 32'(es_load), 32'(op == op_lw));
        check_field("mem_we", 32'(es_mem_we), 32'(op == op_sw));
        check_field("src1_is_sa", 32'(es_src1_is_sa), 32'(shift));
        check_field("src1_is_pc", 32'(es_src1_is_pc), 32'(op == op_jal));
        check_field("imm", 32'(es_imm), 32'(inst[15:0]));
        check_field("pc", es_pc, pc);
    endtask

    task automatic check_vector(input logic [vec_w-1:0] v);
        check_field("ds_to_es_valid", 32'(ds_to_es_valid), 32'(v[132]));
        check_field("ds_allowin", 32'(ds_allowin), 32'(v[128]));
        check_field("br_taken", 32'(br_taken), 32'(v[36]));
        check_field("br_stall", 32'(br_stall), 32'(v[0]));
        if (!v[260]) begin  // flushed stage carries no decode
            check_field("alu_op", 32'(es_alu_op), 32'(v[127:124]));
            check_field("src2_sel", 32'(es_src2_sel), 32'(v[123:120]));
            check_field("dest", 32'(es_dest), 32'(v[116:112]));
            check_field("rs_value", es_rs_value, v[111:80]);
            check_field("rt_value", es_rt_value, v[79:48]);
            check_field("exc_code", 32'(es_exc_code), 32'(v[44:40]));
            if (v[36]) begin  // fetch only uses the target when taken
                check_field("br_target", br_target, v[35:4]);
            end
            check_side_fields(held_inst, held_pc);
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d ok", cur_test);
        end else begin
            $display("test %0d failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // watchdog scaled to the vector count
    initial begin
        #1;
        #((nvec + 40) * 100);
        $display("watchdog: run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        es_allowin = 1'b1;
        exe_dest = '0;
        mem_dest = '0;
        wb_dest = '0;
        exe_result = '0;
        mem_result = '0;
        wb_result = '0;
        exe_load = 1'b0;
        held_inst = '0;
        held_pc = '0;
        errors = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        nvec = 0;
        for (int i = 0; i < max_vecs; i++) vecs[i] = '0;
        $readmemh("bench/id_testdata.txt", vecs);
        while (nvec < max_vecs && vecs[nvec][339:332] != 8'h00) nvec++;
        if (nvec == 0) begin
            $display("no vectors read from bench/id_testdata.txt");
            errors++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (ds_to_es_valid || !ds_allowin || br_taken) begin
            $display("Fail at %0t: stage not idle after reset", $time);
            errors++;
        end
        for (int i = 0; i < nvec; i++) begin
            cur_test = vecs[i][339:332];
            drive_vector(vecs[i]);
            // back-pressure rows leave the earlier instruction in the stage
            if (vecs[i][264]) begin
                held_inst = vecs[i][331:300];
                held_pc   = vecs[i][299:268];
            end
            @(negedge clk);
            check_vector(vecs[i]);
            if (i == nvec - 1 || vecs[i+1][339:332] != cur_test) close_test();
        end
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: bench/id_testdata.txt
// inputs: test inst pc es_allowin flush exe_dest exe_result mem_dest mem_result wb_dest wb_result exe_load
// expect: valid allowin alu_op src2_sel dest rs_value rt_value exc_code br_taken br_target br_stall
01_00000000_00000100_1_0_00_00000000_00_00000000_01_11111111_0_1_1_8_0_00_00000000_00000000_00_0_00000104_0
01_00000000_00000104_1_0_00_00000000_00_00000000_02_22222222_0_1_1_8_0_00_00000000_00000000_00_0_00000108_0
01_00000000_00000108_1_0_00_00000000_00_00000000_03_00000005_0_1_1_8_0_00_00000000_00000000_00_0_0000010c_0
01_00000000_0000010c_1_0_00_00000000_00_00000000_04_00001000_0_1_1_8_0_00_00000000_00000000_00_0_00000110_0
02_00222821_00000110_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_05_11111111_22222222_00_0_0000a198_0
02_2423fffc_00000114_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_2_03_11111111_00000005_00_0_00000108_0
02_34448000_00000118_1_0_00_00000000_00_00000000_00_00000000_0_1_1_5_1_04_22222222_00001000_00_0_fffe011c_0
02_3c021234_0000011c_1_0_00_00000000_00_00000000_00_00000000_0_1_1_b_1_02_00000000_22222222_00_0_000049f0_0
02_8c610008_00000120_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_2_01_00000005_11111111_00_0_00000144_0
02_ac82fffc_00000124_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_2_00_00001000_22222222_00_0_00000118_0
03_00203825_00000128_1_0_00_00000000_00_00000000_00_00000000_0_1_1_5_0_07_11111111_00000000_00_0_0000e1c0_0
03_00003825_0000012c_1_0_00_00000000_00_00000000_00_ffffffff_0_1_1_5_0_07_00000000_00000000_00_0_0000e1c4_0
04_00222821_00000130_1_0_01_aaaaaaaa_01_bbbbbbbb_02_cccccccc_0_1_1_0_0_05_aaaaaaaa_cccccccc_00_0_0000a1b8_0
04_00222821_00000134_1_0_00_00000000_02_dddddddd_02_eeeeeeee_0_1_1_0_0_05_11111111_dddddddd_00_0_0000a1bc_0
04_00003825_00000138_1_0_00_12345678_00_87654321_00_55555555_0_1_1_5_0_07_00000000_00000000_00_0_0000e1d0_0
05_00222821_0000013c_1_0_01_99999999_00_00000000_00_00000000_1_0_0_0_0_05_99999999_eeeeeeee_00_0_0000a1c4_0
05_00222821_00000140_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_05_11111111_eeeeeeee_00_0_0000a1c8_0
05_10630004_00000144_1_0_03_77777777_00_00000000_00_00000000_1_0_0_0_0_00_77777777_77777777_00_1_00000158_1
05_10630004_00000148_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_00000005_00000005_00_1_0000015c_0
06_1422fffe_0000014c_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_11111111_eeeeeeee_00_1_00000148_0
06_10220004_00000150_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_11111111_eeeeeeee_00_0_00000164_0
06_08000040_00000154_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_00000000_00000000_00_1_00000100_0
06_0c000080_00000158_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_3_1f_00000000_00000000_00_1_00000200_0
06_00800008_0000015c_1_0_00_00000000_04_00002000_00_00000000_0_1_1_0_0_00_00002000_00000000_00_1_00002000_0
07_fc000000_00000160_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_00000000_00000000_0a_0_00000164_0
07_0000000c_00000164_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_00000000_00000000_08_0_00000198_0
07_0000000d_00000168_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_00_00000000_00000000_09_0_000001a0_0
07_00222821_0000016c_0_0_00_00000000_00_00000000_00_00000000_0_1_0_0_0_00_00000000_00000000_09_0_000001a0_0
07_00222821_00000170_1_1_00_00000000_00_00000000_00_00000000_0_0_1_0_0_00_00000000_00000000_00_0_00000000_0
07_00222821_00000174_1_0_00_00000000_00_00000000_00_00000000_0_1_1_0_0_05_11111111_eeeeeeee_00_0_0000a1fc_0

// File: list.f
hdl/id_pkg.sv
hdl/id_regfile.sv
hdl/id_decoder.sv
hdl/id_bypass.sv
hdl/id_branch.sv
hdl/id_stage.sv
bench/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f list.f \
    --top-module tb_id_stage -Mdir obj_dir -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_id_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
